//--- hdl/csr_consts.svh
`ifndef CSR_CONSTS_SVH
`define CSR_CONSTS_SVH

// width of every CSR and of the request, trap and response data paths.
`define CSR_XLEN 32

// number of hart register banks in the cluster.
`define CSR_NHARTS 4

// width of a hart index, enough to name every bank.
`define CSR_HART_W 2

// entries in the in-order response queue.
`define CSR_RSP_DEPTH 2

`endif

//--- hdl/csr_pkg.sv
`default_nettype none

package csr_pkg;

  // encodings follow the low two bits of funct3 for csrrw, csrrs and csrrc.
  typedef enum logic [1:0] {
    CSR_OP_RW = 2'b01,
    CSR_OP_RS = 2'b10,
    CSR_OP_RC = 2'b11
  } csr_op_t;

  // machine-mode CSRs implemented per hart.
  typedef enum logic [11:0] {
    CSR_MTVEC   = 12'h305,
    CSR_MEPC    = 12'h341,
    CSR_MCAUSE  = 12'h342,
    CSR_MTVAL   = 12'h343,
    CSR_MHARTID = 12'hF14
  } csr_addr_t;

  // synchronous exception codes that the cluster records.
  typedef enum logic [3:0] {
    TRAP_INST_MISALIGNED = 4'd0,
    TRAP_ILLEGAL_INST    = 4'd2,
    TRAP_BREAKPOINT      = 4'd3,
    TRAP_ECALL_M         = 4'd11
  } trap_cause_t;

endpackage

`default_nettype wire

//--- hdl/csr_hart_if.sv
`timescale 1ns/1ns
`default_nettype none

`include "csr_consts.svh"

interface csr_hart_if;

  logic                   req_valid;
  csr_pkg::csr_op_t       op;
  logic [11:0]            addr;
  logic [`CSR_XLEN-1:0]   wdata;
  logic                   trap_valid;
  csr_pkg::trap_cause_t   trap_cause;
  logic [`CSR_XLEN-1:0]   trap_pc;
  logic [`CSR_XLEN-1:0]   trap_tval;
  logic [`CSR_XLEN-1:0]   rdata;
  logic                   illegal;
  logic [`CSR_XLEN-1:0]   mtvec;

  modport dispatch (output req_valid, op, addr, wdata,
                    output trap_valid, trap_cause, trap_pc, trap_tval);

  modport bank (input req_valid, op, addr, wdata,
                input trap_valid, trap_cause, trap_pc, trap_tval,
                output rdata, illegal, mtvec);

  modport collect (input req_valid, trap_valid, rdata, illegal, mtvec);

endinterface

`default_nettype wire

//--- hdl/csr_dispatch.sv
`timescale 1ns/1ns
`default_nettype none

`include "csr_consts.svh"

module csr_dispatch (
  input  wire logic                   i_req_valid,
  output logic                        o_req_ready,
  input  wire logic [`CSR_HART_W-1:0] i_req_hart,
  input  csr_pkg::csr_op_t            i_req_op,
  input  wire logic [11:0]            i_req_addr,
  input  wire logic [`CSR_XLEN-1:0]   i_req_wdata,
  input  wire logic                   i_trap_valid,
  input  wire logic [`CSR_HART_W-1:0] i_trap_hart,
  input  csr_pkg::trap_cause_t        i_trap_cause,
  input  wire logic [`CSR_XLEN-1:0]   i_trap_pc,
  input  wire logic [`CSR_XLEN-1:0]   i_trap_tval,
  input  wire logic                   i_rsp_space,
  csr_hart_if.dispatch                hart [`CSR_NHARTS]
);

  logic [`CSR_NHARTS-1:0] req_sel;
  logic [`CSR_NHARTS-1:0] trap_sel;
  logic                   trap_hit;
  logic                   req_acc;

  // a trap always wins its bank, so a request to the same hart waits a cycle.
  assign trap_hit    = i_trap_valid && (i_trap_hart == i_req_hart);
  assign o_req_ready = i_rsp_space && !trap_hit;
  assign req_acc     = i_req_valid && o_req_ready;

  always_comb begin
    req_sel  = '0;
    trap_sel = '0;
    req_sel[i_req_hart] = req_acc;
    trap_sel[i_trap_hart] = i_trap_valid;
  end

  // shared fields go to every bank, only the valids are steered.
  for (genvar g = 0; g < `CSR_NHARTS; g++) begin : g_hart
    assign hart[g].req_valid  = req_sel[g];
    assign hart[g].op         = i_req_op;
    assign hart[g].addr       = i_req_addr;
    assign hart[g].wdata      = i_req_wdata;
    assign hart[g].trap_valid = trap_sel[g];
    assign hart[g].trap_cause = i_trap_cause;
    assign hart[g].trap_pc    = i_trap_pc;
    assign hart[g].trap_tval  = i_trap_tval;
  end

endmodule

`default_nettype wire

//--- hdl/csr_hart_bank.sv
`timescale 1ns/1ns
`default_nettype none

`include "csr_consts.svh"

module csr_hart_bank #(
  parameter int HART_ID = 0
) (
  input wire logic i_clk,
  input wire logic i_rst,
  csr_hart_if.bank bus
);

  localparam logic [`CSR_XLEN-1:0] HART_ID_VAL = HART_ID;

  logic [`CSR_XLEN-1:0] mtvec;
  logic [`CSR_XLEN-1:0] mepc;
  logic [`CSR_XLEN-1:0] mcause;
  logic [`CSR_XLEN-1:0] mtval;

  logic [`CSR_XLEN-1:0] cur;
  logic [`CSR_XLEN-1:0] nxt;
  logic                 known;
  logic                 is_hartid;
  logic                 illegal;

  always_comb begin
    cur       = '0;
    known     = 1'b1;
    is_hartid = 1'b0;
    case (bus.addr)
      csr_pkg::CSR_MTVEC:   cur = mtvec;
      csr_pkg::CSR_MEPC:    cur = mepc;
      csr_pkg::CSR_MCAUSE:  cur = mcause;
      csr_pkg::CSR_MTVAL:   cur = mtval;
      csr_pkg::CSR_MHARTID: begin
        cur       = HART_ID_VAL;
        is_hartid = 1'b1;
      end
      default:              known = 1'b0;
    endcase
  end

  // mhartid is read-only, so only a set or clear of no bits may touch it.
  assign illegal = !known ||
                   (is_hartid && ((bus.op == csr_pkg::CSR_OP_RW) || (bus.wdata != '0)));

  always_comb begin
    case (bus.op)
      csr_pkg::CSR_OP_RW: nxt = bus.wdata;
      csr_pkg::CSR_OP_RS: nxt = cur | bus.wdata;
      csr_pkg::CSR_OP_RC: nxt = cur & ~bus.wdata;
      default:            nxt = cur;
    endcase
  end

  assign bus.rdata   = illegal ? '0 : cur;
  assign bus.illegal = illegal;
  assign bus.mtvec   = mtvec;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      mtvec  <= '0;
      mepc   <= '0;
      mcause <= '0;
      mtval  <= '0;
    end else if (bus.trap_valid) begin
      mepc   <= {bus.trap_pc[`CSR_XLEN-1:2], 2'b00};
      mcause <= {{(`CSR_XLEN-4){1'b0}}, bus.trap_cause};
      mtval  <= bus.trap_tval;
    end else if (bus.req_valid && !illegal) begin
      case (bus.addr)
        // direct mode only, so the mode bits of mtvec stay zero.
        csr_pkg::CSR_MTVEC:  mtvec  <= {nxt[`CSR_XLEN-1:2], 2'b00};
        csr_pkg::CSR_MEPC:   mepc   <= {nxt[`CSR_XLEN-1:2], 2'b00};
        csr_pkg::CSR_MCAUSE: mcause <= nxt;
        csr_pkg::CSR_MTVAL:  mtval  <= nxt;
        default: begin
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hdl/csr_collect.sv
`timescale 1ns/1ns
`default_nettype none

`include "csr_consts.svh"

module csr_collect (
  input  wire logic                   i_clk,
  input  wire logic                   i_rst,
  output logic                        o_rsp_valid,
  input  wire logic                   i_rsp_ready,
  output logic [`CSR_XLEN-1:0]        o_rsp_rdata,
  output logic                        o_rsp_illegal,
  output logic                        o_rsp_space,
  output logic                        o_vec_valid,
  output logic [`CSR_HART_W-1:0]      o_vec_hart,
  output logic [`CSR_XLEN-1:0]        o_vec_addr,
  csr_hart_if.collect                 hart [`CSR_NHARTS]
);

  localparam int PTR_W = $clog2(`CSR_RSP_DEPTH);

  logic [`CSR_NHARTS-1:0] req_v;
  logic [`CSR_NHARTS-1:0] trap_v;
  logic [`CSR_XLEN-1:0]   rdata_a [`CSR_NHARTS];
  logic [`CSR_NHARTS-1:0] ill_a;
  logic [`CSR_XLEN-1:0]   mtvec_a [`CSR_NHARTS];

  logic [`CSR_XLEN-1:0]   sel_rdata;
  logic                   sel_ill;
  logic [`CSR_XLEN-1:0]   sel_mtvec;
  logic [`CSR_HART_W-1:0] sel_hart;

  logic [`CSR_XLEN-1:0]   q_rdata [`CSR_RSP_DEPTH];
  logic                   q_ill [`CSR_RSP_DEPTH];
  logic [PTR_W-1:0]       wr_ptr;
  logic [PTR_W-1:0]       rd_ptr;
  logic [PTR_W:0]         count;
  logic                   push;
  logic                   pop;

  for (genvar g = 0; g < `CSR_NHARTS; g++) begin : g_hart
    assign req_v[g]   = hart[g].req_valid;
    assign trap_v[g]  = hart[g].trap_valid;
    assign rdata_a[g] = hart[g].rdata;
    assign ill_a[g]   = hart[g].illegal;
    assign mtvec_a[g] = hart[g].mtvec;
  end

  // the valids are one-hot, so an or-reduce picks the single active bank.
  always_comb begin
    sel_rdata = '0;
    sel_ill   = 1'b0;
    sel_mtvec = '0;
    sel_hart  = '0;
    for (int i = 0; i < `CSR_NHARTS; i++) begin
      if (req_v[i]) begin
        sel_rdata = sel_rdata | rdata_a[i];
        sel_ill   = sel_ill | ill_a[i];
      end
      if (trap_v[i]) begin
        sel_mtvec = sel_mtvec | mtvec_a[i];
        sel_hart  = sel_hart | i[`CSR_HART_W-1:0];
      end
    end
  end

  assign push          = |req_v;
  assign pop           = o_rsp_valid && i_rsp_ready;
  assign o_rsp_valid   = (count != '0);
  assign o_rsp_rdata   = q_rdata[rd_ptr];
  assign o_rsp_illegal = q_ill[rd_ptr];
  assign o_rsp_space   = (count != `CSR_RSP_DEPTH) || pop;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      count       <= '0;
      o_vec_valid <= 1'b0;
      for (int i = 0; i < `CSR_RSP_DEPTH; i++) begin
        q_ill[i] <= 1'b0;
      end
    end else begin
      o_vec_valid <= |trap_v;
      if (push) begin
        q_rdata[wr_ptr] <= sel_rdata;
        q_ill[wr_ptr]   <= sel_ill;
        wr_ptr          <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  // the vector reply carries mtvec as it stood before the trap edge.
  always_ff @(posedge i_clk) begin
    o_vec_hart <= sel_hart;
    o_vec_addr <= sel_mtvec;
  end

endmodule

`default_nettype wire

//--- hdl/csr_cluster_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "csr_consts.svh"

module csr_cluster_top (
  input  wire logic                   i_clk,
  input  wire logic                   i_rst,
  input  wire logic                   i_req_valid,
  output logic                        o_req_ready,
  input  wire logic [`CSR_HART_W-1:0] i_req_hart,
  input  csr_pkg::csr_op_t            i_req_op,
  input  wire logic [11:0]            i_req_addr,
  input  wire logic [`CSR_XLEN-1:0]   i_req_wdata,
  input  wire logic                   i_trap_valid,
  input  wire logic [`CSR_HART_W-1:0] i_trap_hart,
  input  csr_pkg::trap_cause_t        i_trap_cause,
  input  wire logic [`CSR_XLEN-1:0]   i_trap_pc,
  input  wire logic [`CSR_XLEN-1:0]   i_trap_tval,
  output logic                        o_rsp_valid,
  input  wire logic                   i_rsp_ready,
  output logic [`CSR_XLEN-1:0]        o_rsp_rdata,
  output logic                        o_rsp_illegal,
  output logic                        o_vec_valid,
  output logic [`CSR_HART_W-1:0]      o_vec_hart,
  output logic [`CSR_XLEN-1:0]        o_vec_addr
);

  logic rsp_space;

  csr_hart_if hart_if [`CSR_NHARTS] ();

  csr_dispatch u_dispatch (
    .i_req_valid  (i_req_valid),
    .o_req_ready  (o_req_ready),
    .i_req_hart   (i_req_hart),
    .i_req_op     (i_req_op),
    .i_req_addr   (i_req_addr),
    .i_req_wdata  (i_req_wdata),
    .i_trap_valid (i_trap_valid),
    .i_trap_hart  (i_trap_hart),
    .i_trap_cause (i_trap_cause),
    .i_trap_pc    (i_trap_pc),
    .i_trap_tval  (i_trap_tval),
    .i_rsp_space  (rsp_space),
    .hart         (hart_if)
  );

  for (genvar g = 0; g < `CSR_NHARTS; g++) begin : g_bank
    csr_hart_bank #(
      .HART_ID (g)
    ) u_bank (
      .i_clk (i_clk),
      .i_rst (i_rst),
      .bus   (hart_if[g])
    );
  end

  csr_collect u_collect (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .o_rsp_valid   (o_rsp_valid),
    .i_rsp_ready   (i_rsp_ready),
    .o_rsp_rdata   (o_rsp_rdata),
    .o_rsp_illegal (o_rsp_illegal),
    .o_rsp_space   (rsp_space),
    .o_vec_valid   (o_vec_valid),
    .o_vec_hart    (o_vec_hart),
    .o_vec_addr    (o_vec_addr),
    .hart          (hart_if)
  );

endmodule

`default_nettype wire

//--- verification/csr_cluster_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "csr_consts.svh"

module csr_cluster_tb;

  localparam int MAXN = 64;

  logic i_clk, i_rst, i_req_valid, i_trap_valid, i_rsp_ready;
  logic [`CSR_HART_W-1:0] i_req_hart, i_trap_hart, o_vec_hart;
  csr_pkg::csr_op_t i_req_op;
  csr_pkg::trap_cause_t i_trap_cause;
  logic [11:0] i_req_addr;
  logic [`CSR_XLEN-1:0] i_req_wdata, i_trap_pc, i_trap_tval, o_rsp_rdata, o_vec_addr;
  logic o_req_ready, o_rsp_valid, o_rsp_illegal, o_vec_valid;

  // kind 0 is a request, 1 a trap, 2 a trap and a request to the same hart.
  int kind [MAXN];
  logic [`CSR_HART_W-1:0] t_hart [MAXN];
  csr_pkg::csr_op_t t_op [MAXN];
  logic [11:0] t_addr [MAXN];
  csr_pkg::trap_cause_t t_cause [MAXN];
  logic [`CSR_XLEN-1:0] t_wdata [MAXN], t_pc [MAXN], t_tval [MAXN], t_exp [MAXN], t_vec [MAXN];
  logic t_ill [MAXN];
  int n = 0, errors = 0, cycles = 0, limit = 0;

  logic [`CSR_XLEN:0] exp_q [$];
  logic [`CSR_XLEN-1:0] m_tvec [`CSR_NHARTS], m_epc [`CSR_NHARTS];
  logic [`CSR_XLEN-1:0] m_cause [`CSR_NHARTS], m_tval [`CSR_NHARTS];
  logic [15:0] lfsr = 16'd68;

  csr_cluster_top i_dut (.*);

  always #10 i_clk = ~i_clk;

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic check(input string name, input logic [31:0] act, input logic [31:0] exp);
    if (act !== exp) begin
      errors++;
      $display("ERROR at %0t: %s is %h, expected %h", $time, name, act, exp);
    end
  endtask

  task automatic add_req(input int h, input csr_pkg::csr_op_t op, input logic [11:0] addr,
                         input logic [31:0] wdata, input logic [31:0] exp, input logic ill,
                         input bit with_trap);
    int k;
    k = with_trap ? n - 1 : n;
    kind[k] = with_trap ? 2 : 0;
    t_hart[k] = h;
    t_op[k] = op;
    t_addr[k] = addr;
    t_wdata[k] = wdata;
    t_exp[k] = exp;
    t_ill[k] = ill;
    if (!with_trap) n++;
  endtask

  task automatic add_trap(input int h, input csr_pkg::trap_cause_t c, input logic [31:0] pc,
                          input logic [31:0] tval, input logic [31:0] vec);
    kind[n] = 1;
    t_hart[n] = h;
    t_cause[n] = c;
    t_pc[n] = pc;
    t_tval[n] = tval;
    t_vec[n] = vec;
    n++;
  endtask

  // the reference model applies the register rules and returns the old value and the flag.
  task automatic model_req(input int h, input csr_pkg::csr_op_t op, input logic [11:0] addr,
                           input logic [31:0] wd, output logic [31:0] rd, output logic ill);
    logic [31:0] nv;
    rd = 0;
    ill = 0;
    case (addr)
      12'h305: rd = m_tvec[h];
      12'h341: rd = m_epc[h];
      12'h342: rd = m_cause[h];
      12'h343: rd = m_tval[h];
      12'hF14: begin
        rd = h;
        ill = (op == csr_pkg::CSR_OP_RW) || (wd != 0);
      end
      default: ill = 1;
    endcase
    nv = (op == csr_pkg::CSR_OP_RW) ? wd : (op == csr_pkg::CSR_OP_RS) ? (rd | wd) : (rd & ~wd);
    if (ill) rd = 0;
    else if (addr == 12'h305) m_tvec[h] = nv & ~32'h3;
    else if (addr == 12'h341) m_epc[h] = nv & ~32'h3;
    else if (addr == 12'h342) m_cause[h] = nv;
    else if (addr == 12'h343) m_tval[h] = nv;
  endtask

  always @(posedge i_clk) begin
    cycles++;
    if (cycles > limit) begin
      $display("timeout after %0d cycles, the DUT stopped answering", cycles);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  // two LFSR bits per cycle hold ready low about a quarter of the time.
  always @(posedge i_clk) begin
    logic b0;
    lfsr = lfsr_step(lfsr);
    b0 = lfsr[0];
    lfsr = lfsr_step(lfsr);
    i_rsp_ready <= i_rst ? 1'b1 : (b0 | lfsr[0]);
  end

  always @(negedge i_clk) begin
    logic [`CSR_XLEN:0] e;
    if (!i_rst) begin
      if (exp_q.size() == `CSR_RSP_DEPTH && !i_rsp_ready && o_req_ready) begin
        errors++;
        $display("ERROR at %0t: request ready while the response queue is full", $time);
      end
      if (o_rsp_valid && i_rsp_ready) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("ERROR at %0t: response arrived with no request outstanding", $time);
        end else begin
          e = exp_q.pop_front();
          check("o_rsp_rdata", o_rsp_rdata, e[31:0]);
          check("o_rsp_illegal", o_rsp_illegal, e[32]);
        end
      end
    end
  end

  initial begin
    logic [31:0] rd;
    logic ill;
    i_clk = 0;
    i_rst = 1;
    i_req_valid = 0;
    i_trap_valid = 0;
    i_rsp_ready = 1;
    i_req_hart = 0;
    i_trap_hart = 0;
    i_req_op = csr_pkg::CSR_OP_RS;
    i_trap_cause = csr_pkg::TRAP_INST_MISALIGNED;
    i_req_addr = 0;
    i_req_wdata = 0;
    i_trap_pc = 0;
    i_trap_tval = 0;
    for (int h = 0; h < `CSR_NHARTS; h++) begin
      m_tvec[h] = 0;
      m_epc[h] = 0;
      m_cause[h] = 0;
      m_tval[h] = 0;
      add_req(h, csr_pkg::CSR_OP_RS, 12'h305, 0, 0, 0, 0);
      add_req(h, csr_pkg::CSR_OP_RS, 12'h341, 0, 0, 0, 0);
      add_req(h, csr_pkg::CSR_OP_RS, 12'h342, 0, 0, 0, 0);
      add_req(h, csr_pkg::CSR_OP_RS, 12'h343, 0, 0, 0, 0);
      add_req(h, csr_pkg::CSR_OP_RS, 12'hF14, 0, h, 0, 0);
    end
    add_req(1, csr_pkg::CSR_OP_RW, 12'h305, 32'h8000_0103, 0, 0, 0);
    add_req(1, csr_pkg::CSR_OP_RS, 12'h305, 32'h0000_0F00, 32'h8000_0100, 0, 0);
    add_req(1, csr_pkg::CSR_OP_RC, 12'h305, 32'h8000_0000, 32'h8000_0F00, 0, 0);
    add_req(1, csr_pkg::CSR_OP_RS, 12'h305, 0, 32'h0000_0F00, 0, 0);
    add_req(2, csr_pkg::CSR_OP_RW, 12'h341, 32'h1234_5677, 0, 0, 0);
    add_req(2, csr_pkg::CSR_OP_RS, 12'h341, 0, 32'h1234_5674, 0, 0);
    add_req(2, csr_pkg::CSR_OP_RW, 12'h343, 32'hDEAD_BEEF, 0, 0, 0);
    add_req(2, csr_pkg::CSR_OP_RC, 12'h343, 32'h0000_FFFF, 32'hDEAD_BEEF, 0, 0);
    add_req(2, csr_pkg::CSR_OP_RS, 12'h343, 0, 32'hDEAD_0000, 0, 0);
    add_req(0, csr_pkg::CSR_OP_RS, 12'h342, 32'h5, 0, 0, 0);
    add_req(0, csr_pkg::CSR_OP_RS, 12'h342, 0, 32'h5, 0, 0);
    add_req(0, csr_pkg::CSR_OP_RS, 12'h305, 0, 0, 0, 0);
    add_req(3, csr_pkg::CSR_OP_RS, 12'h341, 0, 0, 0, 0);
    add_req(0, csr_pkg::CSR_OP_RW, 12'h300, 32'h1, 0, 1, 0);
    add_req(3, csr_pkg::CSR_OP_RW, 12'hF14, 32'h7, 0, 1, 0);
    add_req(2, csr_pkg::CSR_OP_RS, 12'hF14, 32'h1, 0, 1, 0);
    add_req(2, csr_pkg::CSR_OP_RC, 12'hF14, 0, 32'h2, 0, 0);
    add_req(2, csr_pkg::CSR_OP_RS, 12'h341, 0, 32'h1234_5674, 0, 0);
    add_req(3, csr_pkg::CSR_OP_RS, 12'hF14, 0, 32'h3, 0, 0);
    add_req(0, csr_pkg::CSR_OP_RW, 12'h305, 32'h0000_2000, 0, 0, 0);
    add_trap(0, csr_pkg::TRAP_ECALL_M, 32'h0000_4006, 32'h11, 32'h2000);
    add_req(0, csr_pkg::CSR_OP_RS, 12'h341, 0, 32'h0000_4004, 0, 0);
    add_req(0, csr_pkg::CSR_OP_RS, 12'h342, 0, 32'd11, 0, 0);
    add_req(0, csr_pkg::CSR_OP_RS, 12'h343, 0, 32'h11, 0, 0);
    add_req(1, csr_pkg::CSR_OP_RS, 12'h341, 0, 0, 0, 0);
    add_trap(1, csr_pkg::TRAP_ILLEGAL_INST, 32'h100, 32'hBAD, 32'hF00);
    add_trap(2, csr_pkg::TRAP_BREAKPOINT, 32'h0000_0808, 32'h55, 0);
    add_req(2, csr_pkg::CSR_OP_RS, 12'h342, 0, 32'd3, 0, 1);
    add_req(2, csr_pkg::CSR_OP_RS, 12'h341, 0, 32'h0000_0808, 0, 0);
    add_req(1, csr_pkg::CSR_OP_RS, 12'h342, 0, 32'd2, 0, 0);
    limit = 8 * n + 50;
    repeat (2) @(posedge i_clk);
    i_rst <= 0;
    @(negedge i_clk);
    check("o_rsp_valid", o_rsp_valid, 0);
    check("o_vec_valid", o_vec_valid, 0);
    check("o_rsp_illegal", o_rsp_illegal, 0);
    for (int i = 0; i < n; i++) begin
      @(posedge i_clk);
      if (kind[i] != 0) begin
        i_trap_valid <= 1;
        i_trap_hart <= t_hart[i];
        i_trap_cause <= t_cause[i];
        i_trap_pc <= t_pc[i];
        i_trap_tval <= t_tval[i];
      end
      if (kind[i] != 1) begin
        i_req_valid <= 1;
        i_req_hart <= t_hart[i];
        i_req_op <= t_op[i];
        i_req_addr <= t_addr[i];
        i_req_wdata <= t_wdata[i];
      end
      @(negedge i_clk);
      // no trap reached the last edge, so the vector reply must be idle.
      check("o_vec_valid", o_vec_valid, 0);
      if (kind[i] == 2) check("o_req_ready", o_req_ready, 0);
      if (kind[i] != 0) begin
        @(posedge i_clk);
        i_trap_valid <= 0;
        check("model mtvec", m_tvec[t_hart[i]], t_vec[i]);
        m_epc[t_hart[i]] = t_pc[i] & ~32'h3;
        m_cause[t_hart[i]] = t_cause[i];
        m_tval[t_hart[i]] = t_tval[i];
        @(negedge i_clk);
        check("o_vec_valid", o_vec_valid, 1);
        check("o_vec_hart", o_vec_hart, t_hart[i]);
        check("o_vec_addr", o_vec_addr, t_vec[i]);
      end
      if (kind[i] != 1) begin
        while (!o_req_ready) @(negedge i_clk);
        @(posedge i_clk);
        i_req_valid <= 0;
        model_req(t_hart[i], t_op[i], t_addr[i], t_wdata[i], rd, ill);
        check("model rdata", rd, t_exp[i]);
        check("model illegal", ill, t_ill[i]);
        exp_q.push_back({t_ill[i], t_exp[i]});
        @(negedge i_clk);
        check("o_rsp_valid", o_rsp_valid, 1);
      end
    end
    while (exp_q.size() != 0) @(negedge i_clk);
    $display("%0d entries applied, %0d errors", n, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
+incdir+hdl
hdl/csr_pkg.sv
hdl/csr_hart_if.sv
hdl/csr_dispatch.sv
hdl/csr_hart_bank.sv
hdl/csr_collect.sv
hdl/csr_cluster_top.sv
verification/csr_cluster_tb.sv
